// File: design/pim_cfg_pkg.sv
// ======================================================================
// geometry of the 5x5 slice-split convolution engine
// operands are unsigned, split into two disjoint 3-bit slices
// out_w is sized for 25 * 63 * 63 = 99225, the exact maximum
// ======================================================================

package pim_cfg_pkg;

	// window positions of a 5x5 kernel
	localparam int taps = 25;

	localparam int data_w = 6; // full operand width
	localparam int slice_w = 3; // hi and lo slice width

	// one crossbar per (weight slice, data slice) pair
	// order is HH, HL, LH, LL
	localparam int n_units = 4;

	// merged result width
	// HH << 6 + (HL + LH) << 3 + LL
	localparam int out_w = 18;

endpackage

// File: design/pim_conv_core.sv
// ======================================================================
// 5x5 PIM convolution engine, three stages from compute to out_valid
// no back-pressure; compute may fire every cycle
// set ADC_BITS to 11 for a lossless result
// ======================================================================

module pim_conv_core #(
	parameter int ROWS = 4,
	parameter int ADC_BITS = 10
) (
	input logic clk,
	input logic rst_n,
	input logic compute,
	input logic [((ROWS > 1) ? $clog2(ROWS) : 1)-1:0] k_addr,
	input pim_types_pkg::window_t window,
	input logic wr_en,
	input logic [((ROWS > 1) ? $clog2(ROWS) : 1)-1:0] wr_addr,
	input logic [$clog2(pim_cfg_pkg::taps)-1:0] wr_tap,
	input pim_types_pkg::pixel_t wr_weight,
	output logic [pim_cfg_pkg::out_w-1:0] conv_out,
	output logic out_valid
);

	localparam int addr_w = (ROWS > 1) ? $clog2(ROWS) : 1;

	logic [addr_w-1:0] row_sel;
	pim_types_pkg::slice_vec_t data_hi;
	pim_types_pkg::slice_vec_t data_lo;
	logic stage_valid;
	logic [ADC_BITS-1:0] psum [pim_cfg_pkg::n_units];
	logic [pim_cfg_pkg::n_units-1:0] unit_valid; // all units run in lockstep

	window_slicer #(.ROWS(ROWS)) window_slicer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.compute(compute),
		.k_addr(k_addr),
		.window(window),
		.row_sel(row_sel),
		.data_hi(data_hi),
		.data_lo(data_lo),
		.stage_valid(stage_valid)
	);

	// index bit 1 low selects the weight hi slice, bit 0 low the data hi slice
	for (genvar i = 0; i < pim_cfg_pkg::n_units; i++)
	begin : g_unit
		pim_crossbar #(
			.ROWS(ROWS),
			.ADC_BITS(ADC_BITS),
			.W_HI((i & 2) == 0),
			.D_HI((i & 1) == 0)
		) pim_crossbar_inst (
			.clk(clk),
			.rst_n(rst_n),
			.wr_en(wr_en),
			.wr_addr(wr_addr),
			.wr_tap(wr_tap),
			.wr_weight(wr_weight),
			.row_sel(row_sel),
			.data_hi(data_hi),
			.data_lo(data_lo),
			.stage_valid(stage_valid),
			.psum(psum[i]),
			.psum_valid(unit_valid[i])
		);
	end

	shift_add_merge #(.ADC_BITS(ADC_BITS)) shift_add_merge_inst (
		.clk(clk),
		.rst_n(rst_n),
		.psum_hh(psum[0]),
		.psum_hl(psum[1]),
		.psum_lh(psum[2]),
		.psum_ll(psum[3]),
		.psum_valid(unit_valid[0]),
		.conv_out(conv_out),
		.out_valid(out_valid)
	);

endmodule

// File: design/pim_crossbar.sv
// ======================================================================
// one slice crossbar: ROWS kernels of 25 weight slices, 25-term dot
// product with a saturating ADC of ADC_BITS; 11 bits are lossless
// a weight write lands one cycle late, after the compute beside it
// ======================================================================

module pim_crossbar #(
	parameter int ROWS = 4,
	parameter int ADC_BITS = 10,
	parameter bit W_HI = 1'b1, // store the weight hi slice
	parameter bit D_HI = 1'b1 // take the data hi slice
) (
	input logic clk,
	input logic rst_n,
	input logic wr_en,
	input logic [((ROWS > 1) ? $clog2(ROWS) : 1)-1:0] wr_addr,
	input logic [$clog2(pim_cfg_pkg::taps)-1:0] wr_tap,
	input pim_types_pkg::pixel_t wr_weight,
	input logic [((ROWS > 1) ? $clog2(ROWS) : 1)-1:0] row_sel,
	input pim_types_pkg::slice_vec_t data_hi,
	input pim_types_pkg::slice_vec_t data_lo,
	input logic stage_valid,
	output logic [ADC_BITS-1:0] psum,
	output logic psum_valid
);

	localparam int addr_w = (ROWS > 1) ? $clog2(ROWS) : 1;
	localparam int tap_w = $clog2(pim_cfg_pkg::taps);
	localparam int slice_max = (1 << pim_cfg_pkg::slice_w) - 1;
	localparam int sum_w = $clog2(pim_cfg_pkg::taps * slice_max * slice_max + 1);
	localparam int adc_max = (1 << ADC_BITS) - 1;

	pim_types_pkg::slice_t w_mem [ROWS][pim_cfg_pkg::taps];
	pim_types_pkg::operand_u wr_op;
	pim_types_pkg::slice_vec_t data_sel;

	logic wr_pend;
	logic [addr_w-1:0] wr_addr_q;
	logic [tap_w-1:0] wr_tap_q;
	pim_types_pkg::slice_t wr_slice_q;
	logic [sum_w-1:0] acc;

	assign wr_op = pim_types_pkg::operand_u'(wr_weight);
	assign data_sel = D_HI ? data_hi : data_lo;

	// hold the write for a cycle so a compute sampled with it reads old data
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			wr_pend <= 1'b0;
		else
			wr_pend <= wr_en;
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			wr_addr_q <= wr_addr;
			wr_tap_q <= wr_tap;
			wr_slice_q <= W_HI ? wr_op.slices.hi : wr_op.slices.lo;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int r = 0; r < ROWS; r++)
				for (int t = 0; t < pim_cfg_pkg::taps; t++)
					w_mem[r][t] <= '0;
		end
		else if (wr_pend)
			w_mem[wr_addr_q][wr_tap_q] <= wr_slice_q;
	end

	// bit-line sum over the selected row
	always_comb
	begin
		acc = '0;
		for (int t = 0; t < pim_cfg_pkg::taps; t++)
			acc += sum_w'(w_mem[row_sel][t]) * sum_w'(data_sel[t]);
	end

	always_ff @(posedge clk)
	begin
		if (stage_valid)
			psum <= (acc > adc_max) ? ADC_BITS'(adc_max) : ADC_BITS'(acc); // adc clamp
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			psum_valid <= 1'b0;
		else
			psum_valid <= stage_valid;
	end

	a_wr_tap_range: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> (wr_tap < pim_cfg_pkg::taps));
	a_wr_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> (wr_addr < ROWS));

endmodule

// File: design/pim_types_pkg.sv
// ======================================================================
// operand, slice and window types for the convolution engine
// window_t and slice_vec_t index tap 0 at the lowest bits
// ======================================================================

package pim_types_pkg;

	// one unsigned operand, pixel or weight
	typedef logic [pim_cfg_pkg::data_w-1:0] pixel_t;

	typedef logic [pim_cfg_pkg::slice_w-1:0] slice_t;

	// hi sits in the upper bits, so it overlays pixel_t exactly
	typedef struct packed {
		slice_t hi;
		slice_t lo;
	} slice_pair_t;

	// same 6-bit word read as a number or as its two slices
	typedef union packed {
		pixel_t value; // arithmetic view
		slice_pair_t slices; // crossbar view
	} operand_u;

	// whole 5x5 window, 150 bits
	typedef pixel_t [pim_cfg_pkg::taps-1:0] window_t;

	// one slice from every tap, 75 bits
	typedef slice_t [pim_cfg_pkg::taps-1:0] slice_vec_t;

endpackage

// File: design/shift_add_merge.sv
// ======================================================================
// weights the four slice sums by significance and adds them
// result is exact only while no crossbar saturated (ADC_BITS >= 11)
// conv_out holds its last value between out_valid pulses
// ======================================================================

module shift_add_merge #(
	parameter int ADC_BITS = 10
) (
	input logic clk,
	input logic rst_n,
	input logic [ADC_BITS-1:0] psum_hh,
	input logic [ADC_BITS-1:0] psum_hl,
	input logic [ADC_BITS-1:0] psum_lh,
	input logic [ADC_BITS-1:0] psum_ll,
	input logic psum_valid,
	output logic [pim_cfg_pkg::out_w-1:0] conv_out,
	output logic out_valid
);

	localparam int ow = pim_cfg_pkg::out_w;

	logic [ow-1:0] hh_term; // hi x hi, weight 64
	logic [ow-1:0] cross_term; // hi x lo both ways, weight 8
	logic [ow-1:0] ll_term;
	logic [ow-1:0] merged;

	assign hh_term = ow'(psum_hh) << (2 * pim_cfg_pkg::slice_w);
	assign cross_term = (ow'(psum_hl) + ow'(psum_lh)) << pim_cfg_pkg::slice_w;
	assign ll_term = ow'(psum_ll);
	assign merged = hh_term + cross_term + ll_term;

	always_ff @(posedge clk)
	begin
		if (psum_valid)
			conv_out <= merged;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= psum_valid;
	end

	// every partial sum is known when it is merged
	a_psum_known: assert property (@(posedge clk) disable iff (!rst_n)
		psum_valid |-> !$isunknown({psum_hh, psum_hl, psum_lh, psum_ll}));

endmodule

// File: design/window_slicer.sv
// ======================================================================
// input stage: captures window and kernel address on compute
// slices are split from the captured window, so they hold between
// computes; stage_valid is a one-cycle pulse per compute
// ======================================================================

module window_slicer #(
	parameter int ROWS = 4
) (
	input logic clk,
	input logic rst_n,
	input logic compute,
	input logic [((ROWS > 1) ? $clog2(ROWS) : 1)-1:0] k_addr,
	input pim_types_pkg::window_t window,
	output logic [((ROWS > 1) ? $clog2(ROWS) : 1)-1:0] row_sel,
	output pim_types_pkg::slice_vec_t data_hi,
	output pim_types_pkg::slice_vec_t data_lo,
	output logic stage_valid
);

	pim_types_pkg::window_t win_q; // captured window
	pim_types_pkg::operand_u op; // per-tap decode view

	// payload capture, only moves on compute
	always_ff @(posedge clk)
	begin
		if (compute)
		begin
			win_q <= window;
			row_sel <= k_addr;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			stage_valid <= 1'b0;
		else
			stage_valid <= compute; // one stage behind the strobe
	end

	// split every pixel into its two slices
	always_comb
	begin
		for (int t = 0; t < pim_cfg_pkg::taps; t++)
		begin
			op.value = win_q[t];
			data_hi[t] = op.slices.hi;
			data_lo[t] = op.slices.lo;
		end
	end

	// an unknown strobe would corrupt the whole pipeline downstream
	a_compute_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(compute));

endmodule

// File: filelist.f
design/pim_cfg_pkg.sv
design/pim_types_pkg.sv
design/window_slicer.sv
design/pim_crossbar.sv
design/shift_add_merge.sv
design/pim_conv_core.sv
tests/tb_pim_conv_core.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it
# exit status is non-zero when the build or the simulation fails
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal \
	--top-module tb_pim_conv_core \
	-f filelist.f \
	-o sim_tb_pim_conv_core &&
./obj_dir/sim_tb_pim_conv_core ||
{
	echo "simulation failed"
	exit 1
}

// File: tests/tb_pim_conv_core.sv
// ======================================================================
// self-checking testbench for pim_conv_core, ROWS 4 and ADC_BITS 10
// expected results come from a slice model with the ADC clamp at 1023
// inputs change on the falling edge, checks run on the rising edge
// ======================================================================

module tb_pim_conv_core;

	localparam int rows = 4;
	localparam int adc_bits = 10;
	localparam int period = 40;
	localparam int n_single = 16;
	localparam int n_burst = 16;
	localparam int n_writes = 2 * rows * pim_cfg_pkg::taps + 1;
	localparam int n_computes = 1 + n_single + n_burst + 2 + 1;
	// single computes drain before the next one, so up to 4 cycles each
	localparam int timeout_cycles = n_writes + 4 * n_computes + 20;

	logic clk;
	logic rst_n;
	logic compute;
	logic [1:0] k_addr;
	pim_types_pkg::window_t window;
	logic wr_en;
	logic [1:0] wr_addr;
	logic [4:0] wr_tap;
	pim_types_pkg::pixel_t wr_weight;
	logic [pim_cfg_pkg::out_w-1:0] conv_out;
	logic out_valid;

	pim_types_pkg::pixel_t model_w [rows][pim_cfg_pkg::taps]; // full weights
	logic [pim_cfg_pkg::out_w-1:0] exp_q [$];
	logic [2:0] valid_pipe; // computes in flight, oldest at bit 2
	logic [31:0] lcg_state = 32'hf946;

	pim_conv_core #(.ROWS(rows), .ADC_BITS(adc_bits)) pim_conv_core_inst (
		.clk(clk),
		.rst_n(rst_n),
		.compute(compute),
		.k_addr(k_addr),
		.window(window),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_tap(wr_tap),
		.wr_weight(wr_weight),
		.conv_out(conv_out),
		.out_valid(out_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial
	begin
		#(timeout_cycles * period);
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog expired, results did not drain in time");
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic pim_types_pkg::pixel_t rand_pixel();
		logic [31:0] r;
		r = lcg_next();
		return r[29:24]; // upper bits, better spread
	endfunction

	function automatic pim_types_pkg::window_t rand_window();
		pim_types_pkg::window_t w;
		for (int t = 0; t < pim_cfg_pkg::taps; t++)
			w[t] = rand_pixel();
		return w;
	endfunction

	// four slice dot products, each clamped, then weighted 64 / 8 / 8 / 1
	function automatic logic [pim_cfg_pkg::out_w-1:0] expected_conv(
		input pim_types_pkg::window_t win, input logic [1:0] addr);
		int unsigned part [4];
		int unsigned w_sl;
		int unsigned d_sl;
		for (int u = 0; u < 4; u++)
		begin
			part[u] = 0;
			for (int t = 0; t < pim_cfg_pkg::taps; t++)
			begin
				w_sl = (u < 2) ? (model_w[addr][t] >> 3) : (model_w[addr][t] & 6'h07);
				d_sl = (u % 2 == 0) ? (win[t] >> 3) : (win[t] & 6'h07);
				part[u] += w_sl * d_sl;
			end
			if (part[u] > (1 << adc_bits) - 1)
				part[u] = (1 << adc_bits) - 1; // adc clamp
		end
		return (part[0] << 6) + ((part[1] + part[2]) << 3) + part[3];
	endfunction

	task automatic check_out(input logic [pim_cfg_pkg::out_w-1:0] actual,
		input logic [pim_cfg_pkg::out_w-1:0] expected);
		if (actual !== expected)
		begin
			$display("Error: conv_out is %h, expected %h", actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "conv_out mismatch");
		end
	endtask

	task automatic check_valid(input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("Error: out_valid is %h, expected %h", actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "out_valid mismatch");
		end
	endtask

	// sets every DUT input for one cycle
	task automatic drive(input logic cmp, input logic [1:0] ka,
		input pim_types_pkg::window_t win, input logic we, input logic [1:0] wa,
		input logic [4:0] wt, input pim_types_pkg::pixel_t ww);
		@(negedge clk);
		compute = cmp;
		k_addr = ka;
		window = win;
		wr_en = we;
		wr_addr = wa;
		wr_tap = wt;
		wr_weight = ww;
	endtask

	task automatic idle();
		drive(1'b0, 2'd0, '0, 1'b0, 2'd0, 5'd0, '0);
	endtask

	task automatic wait_drain();
		idle();
		while (exp_q.size() != 0 || valid_pipe != 3'b000)
			idle();
	endtask

	// model runs on the sampled inputs, compute before the write beside it
	always @(posedge clk)
	begin
		if (!rst_n)
			valid_pipe = 3'b000;
		else
		begin
			check_valid(out_valid, valid_pipe[2]);
			if (out_valid)
				check_out(conv_out, exp_q.pop_front());
			valid_pipe = {valid_pipe[1:0], compute};
			if (compute)
				exp_q.push_back(expected_conv(window, k_addr));
			if (wr_en)
				model_w[wr_addr][wr_tap] = wr_weight;
		end
	end

	initial
	begin
		pim_types_pkg::window_t win;
		pim_types_pkg::pixel_t w_old;
		logic [1:0] row;
		logic [4:0] tap;
		logic [31:0] r;
		compute = 1'b0;
		k_addr = 2'd0;
		window = '0;
		wr_en = 1'b0;
		wr_addr = 2'd0;
		wr_tap = 5'd0;
		wr_weight = '0;
		rst_n = 1'b0;
		for (int a = 0; a < rows; a++)
			for (int t = 0; t < pim_cfg_pkg::taps; t++)
				model_w[a][t] = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// idle after reset, then a compute on zero weights
		repeat (4) idle();
		drive(1'b1, 2'd1, rand_window(), 1'b0, 2'd0, 5'd0, '0);
		wait_drain();
		check_out(conv_out, '0);

		for (int a = 0; a < rows; a++)
			for (int t = 0; t < pim_cfg_pkg::taps; t++)
				drive(1'b0, 2'd0, '0, 1'b1, 2'(a), 5'(t), rand_pixel());
		for (int n = 0; n < n_single; n++)
		begin
			r = lcg_next();
			drive(1'b1, r[31:30], rand_window(), 1'b0, 2'd0, 5'd0, '0);
			wait_drain();
		end

		// back-to-back burst
		for (int n = 0; n < n_burst; n++)
		begin
			r = lcg_next();
			drive(1'b1, r[31:30], rand_window(), 1'b0, 2'd0, 5'd0, '0);
		end
		wait_drain();

		// rewrite one weight in the same cycle as a compute on its row
		r = lcg_next();
		row = r[31:30];
		tap = 5'(r[28:24] % pim_cfg_pkg::taps);
		win = rand_window();
		win[tap] = 6'h3f; // makes the changed weight count
		w_old = model_w[row][tap];
		drive(1'b1, row, win, 1'b1, row, tap, w_old ^ 6'h3f);
		drive(1'b1, row, win, 1'b0, 2'd0, 5'd0, '0);
		wait_drain();

		// every slice sum clamps
		for (int a = 0; a < rows; a++)
			for (int t = 0; t < pim_cfg_pkg::taps; t++)
				drive(1'b0, 2'd0, '0, 1'b1, 2'(a), 5'(t), 6'h3f);
		for (int t = 0; t < pim_cfg_pkg::taps; t++)
			win[t] = 6'h3f;
		r = lcg_next();
		drive(1'b1, r[31:30], win, 1'b0, 2'd0, 5'd0, '0);
		wait_drain();
		check_out(conv_out, 18'd82863);

		if (exp_q.size() != 0 || valid_pipe != 3'b000)
		begin
			$display("*** TEST FAILED ***");
			$fatal(1, "results still pending at the end of the run");
		end
		else
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule
